// ==== design/md5_settings.svh ====
`ifndef MD5_SETTINGS_SVH
`define MD5_SETTINGS_SVH

`default_nettype none

// Datapath widths
`define MD5_WORD_W      32
`define MD5_BLOCK_W     512
`define MD5_STATE_W     128

`define MD5_STEPS       16      // Steps per round
`define MD5_STAGE_LAT   17      // Round stage strobe to strobe

// Standard initial chaining words
`define MD5_IV_A        32'h67452301
`define MD5_IV_B        32'hefcdab89
`define MD5_IV_C        32'h98badcfe
`define MD5_IV_D        32'h10325476

`default_nettype wire

`endif

// ==== design/md5_pkg.sv ====
`include "md5_settings.svh"
`default_nettype none

package md5_pkg;

    typedef logic [`MD5_WORD_W-1:0] word_t;

    // Word A sits in the low 32 bits
    typedef struct packed {
        word_t d;
        word_t c;
        word_t b;
        word_t a;
    } state_t;

    typedef logic [`MD5_BLOCK_W-1:0] block_t;              // Word 0 in the low bits
    typedef logic [$clog2(`MD5_STEPS)-1:0] step_t;

    // Round function, one per pipeline stage
    typedef enum logic [1:0] {
        RND_F,
        RND_G,
        RND_H,
        RND_I
    } round_e;

    typedef enum logic {
        ST_IDLE,
        ST_RUN
    } stage_state_e;

endpackage

`default_nettype wire

// ==== design/md5_const_rom.sv ====
`timescale 1ns/1ns
`include "md5_settings.svh"
`default_nettype none

module md5_const_rom
    import md5_pkg::*;
#(
    parameter round_e ROUND = RND_F
)
(
    input  wire step_t  i_step,
    output word_t       o_k,
    output logic [4:0]  o_shift,
    output step_t       o_word_idx
);

    // Additive constants, sixteen per round
    localparam word_t K_F [16] = '{
        32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
        32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
        32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
        32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821
    };
    localparam word_t K_G [16] = '{
        32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
        32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
        32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
        32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a
    };
    localparam word_t K_H [16] = '{
        32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
        32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
        32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
        32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665
    };
    localparam word_t K_I [16] = '{
        32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
        32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
        32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
        32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
    };

    // Rotate amounts repeat every four steps
    localparam logic [4:0] S_F [4] = '{5'd7, 5'd12, 5'd17, 5'd22};
    localparam logic [4:0] S_G [4] = '{5'd5, 5'd9,  5'd14, 5'd20};
    localparam logic [4:0] S_H [4] = '{5'd4, 5'd11, 5'd16, 5'd23};
    localparam logic [4:0] S_I [4] = '{5'd6, 5'd10, 5'd15, 5'd21};

    always_comb
    begin
        unique case (ROUND)
            RND_F:
            begin
                o_k        = K_F[i_step];
                o_shift    = S_F[i_step[1:0]];
                o_word_idx = i_step;
            end
            RND_G:
            begin
                o_k        = K_G[i_step];
                o_shift    = S_G[i_step[1:0]];
                o_word_idx = step_t'(4'd1 + 4'd5 * i_step);   // Wraps mod 16
            end
            RND_H:
            begin
                o_k        = K_H[i_step];
                o_shift    = S_H[i_step[1:0]];
                o_word_idx = step_t'(4'd5 + 4'd3 * i_step);
            end
            RND_I:
            begin
                o_k        = K_I[i_step];
                o_shift    = S_I[i_step[1:0]];
                o_word_idx = step_t'(4'd7 * i_step);
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/md5_round_stage.sv ====
`timescale 1ns/1ns
`include "md5_settings.svh"
`default_nettype none

module md5_round_stage
    import md5_pkg::*;
#(
    parameter round_e ROUND = RND_F
)
(
    input  wire logic   Clk,
    input  wire logic   Rst_n,
    input  wire logic   i_valid,
    input  wire state_t i_state,
    input  wire block_t i_block,
    input  wire state_t i_chain,
    output logic        o_valid,
    output state_t      o_state,
    output block_t      o_block,
    output state_t      o_chain
);

    stage_state_e st_q;
    step_t        step_q;
    state_t       work_q;       // Working words A to D
    block_t       block_q;
    state_t       chain_q;

    word_t        k_val;
    logic [4:0]   shift;
    step_t        word_idx;
    word_t        f_val;
    word_t        m_val;
    word_t        sum;
    logic [2*`MD5_WORD_W-1:0] rot_dbl;
    word_t        step_res;
    state_t       work_nxt;
    logic         last_step;

    md5_const_rom #(
        .ROUND      (ROUND)
    ) u_rom (
        .i_step     (step_q),
        .o_k        (k_val),
        .o_shift    (shift),
        .o_word_idx (word_idx)
    );

    // Round function on B, C, D
    always_comb
    begin
        unique case (ROUND)
            RND_F: f_val = (work_q.b & work_q.c) | (~work_q.b & work_q.d);
            RND_G: f_val = (work_q.b & work_q.d) | (work_q.c & ~work_q.d);
            RND_H: f_val = work_q.b ^ work_q.c ^ work_q.d;
            RND_I: f_val = work_q.c ^ (work_q.b | ~work_q.d);
        endcase
    end

    assign m_val    = block_q[word_idx*`MD5_WORD_W +: `MD5_WORD_W];
    assign sum      = work_q.a + f_val + k_val + m_val;
    assign rot_dbl  = {sum, sum} << shift;                  // Upper half is the left rotate
    assign step_res = work_q.b + rot_dbl[2*`MD5_WORD_W-1 -: `MD5_WORD_W];

    always_comb
    begin
        work_nxt.a = work_q.d;
        work_nxt.b = step_res;
        work_nxt.c = work_q.b;
        work_nxt.d = work_q.c;
    end

    assign last_step = (st_q == ST_RUN) && (step_q == step_t'(`MD5_STEPS - 1));

    always_ff @(posedge Clk or posedge Rst_n)
    begin
        if (Rst_n)
        begin
            st_q    <= ST_IDLE;
            step_q  <= '0;
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= last_step;                           // One cycle pulse
            unique case (st_q)
                ST_IDLE:
                begin
                    step_q <= '0;
                    if (i_valid)
                        st_q <= ST_RUN;
                end
                ST_RUN:
                begin
                    step_q <= step_q + 1'b1;
                    if (last_step)
                        st_q <= ST_IDLE;
                end
            endcase
        end
    end

    // A strobe during ST_RUN is dropped
    always_ff @(posedge Clk)
    begin
        if (st_q == ST_IDLE && i_valid)
        begin
            work_q  <= i_state;
            block_q <= i_block;
            chain_q <= i_chain;
        end
        else if (st_q == ST_RUN)
            work_q <= work_nxt;

        // Outputs hold until the next block finishes
        if (last_step)
        begin
            o_state <= work_nxt;
            o_block <= block_q;
            o_chain <= chain_q;
        end
    end

endmodule

`default_nettype wire

// ==== design/md5_digest_stage.sv ====
`timescale 1ns/1ns
`include "md5_settings.svh"
`default_nettype none

module md5_digest_stage
    import md5_pkg::*;
(
    input  wire logic   Clk,
    input  wire logic   Rst_n,
    input  wire logic   i_valid,
    input  wire state_t i_state,
    input  wire state_t i_chain,
    output logic        o_valid,
    output state_t      o_digest
);

    always_ff @(posedge Clk or posedge Rst_n)
    begin
        if (Rst_n)
            o_valid <= 1'b0;
        else
            o_valid <= i_valid;
    end

    // Feed-forward add, each word mod 2^32
    always_ff @(posedge Clk)
    begin
        if (i_valid)
        begin
            o_digest.a <= i_state.a + i_chain.a;
            o_digest.b <= i_state.b + i_chain.b;
            o_digest.c <= i_state.c + i_chain.c;
            o_digest.d <= i_state.d + i_chain.d;
        end
    end

endmodule

`default_nettype wire

// ==== design/md5_core.sv ====
`timescale 1ns/1ns
`include "md5_settings.svh"
`default_nettype none

module md5_core
    import md5_pkg::*;
(
    input  wire logic   Clk,
    input  wire logic   Rst_n,
    input  wire logic   i_valid,
    input  wire block_t i_block,
    input  wire state_t i_chain,
    output logic        o_valid,
    output state_t      o_digest
);

    // Stage outputs, index 0 is round F
    logic   rnd_valid [4];
    state_t rnd_state [4];
    block_t rnd_block [3];      // Last round's block is not needed
    state_t rnd_chain [4];

    // Round F starts from the chaining value itself
    md5_round_stage #(.ROUND(RND_F)) u_rnd_f (
        .Clk     (Clk),
        .Rst_n   (Rst_n),
        .i_valid (i_valid),
        .i_state (i_chain),
        .i_block (i_block),
        .i_chain (i_chain),
        .o_valid (rnd_valid[0]),
        .o_state (rnd_state[0]),
        .o_block (rnd_block[0]),
        .o_chain (rnd_chain[0])
    );

    md5_round_stage #(.ROUND(RND_G)) u_rnd_g (
        .Clk     (Clk),
        .Rst_n   (Rst_n),
        .i_valid (rnd_valid[0]),
        .i_state (rnd_state[0]),
        .i_block (rnd_block[0]),
        .i_chain (rnd_chain[0]),
        .o_valid (rnd_valid[1]),
        .o_state (rnd_state[1]),
        .o_block (rnd_block[1]),
        .o_chain (rnd_chain[1])
    );

    md5_round_stage #(.ROUND(RND_H)) u_rnd_h (
        .Clk     (Clk),
        .Rst_n   (Rst_n),
        .i_valid (rnd_valid[1]),
        .i_state (rnd_state[1]),
        .i_block (rnd_block[1]),
        .i_chain (rnd_chain[1]),
        .o_valid (rnd_valid[2]),
        .o_state (rnd_state[2]),
        .o_block (rnd_block[2]),
        .o_chain (rnd_chain[2])
    );

    md5_round_stage #(.ROUND(RND_I)) u_rnd_i (
        .Clk     (Clk),
        .Rst_n   (Rst_n),
        .i_valid (rnd_valid[2]),
        .i_state (rnd_state[2]),
        .i_block (rnd_block[2]),
        .i_chain (rnd_chain[2]),
        .o_valid (rnd_valid[3]),
        .o_state (rnd_state[3]),
        .o_block (),
        .o_chain (rnd_chain[3])
    );

    md5_digest_stage u_digest (
        .Clk      (Clk),
        .Rst_n    (Rst_n),
        .i_valid  (rnd_valid[3]),
        .i_state  (rnd_state[3]),
        .i_chain  (rnd_chain[3]),
        .o_valid  (o_valid),
        .o_digest (o_digest)
    );

endmodule

`default_nettype wire

// ==== dv/md5_core_assert.sv ====
`timescale 1ns/1ns
`include "md5_settings.svh"
`default_nettype none

module md5_core_assert
(
    input  wire logic Clk,
    input  wire logic Rst_n,
    input  wire logic i_valid,
    input  wire logic o_valid
);

    localparam int LATENCY = 4 * `MD5_STAGE_LAT + 1;

    logic [7:0] since_rst;      // Cycles since reset release, saturating
    logic [4:0] since_in;       // Cycles since the last input strobe

    always_ff @(posedge Clk or posedge Rst_n)
    begin
        if (Rst_n)
        begin
            since_rst <= '0;
            since_in  <= '1;
        end
        else
        begin
            if (since_rst != '1)
                since_rst <= since_rst + 8'd1;
            if (i_valid)
                since_in <= '0;
            else if (since_in != '1)
                since_in <= since_in + 5'd1;
        end
    end

    a_out_pulse: assert property (@(posedge Clk) disable iff (Rst_n)
        o_valid |-> !$past(o_valid))
        else $error("o_valid stayed high for two cycles");

    // Every accepted block comes out after the fixed pipeline latency
    a_latency_fwd: assert property (@(posedge Clk) disable iff (Rst_n)
        ($past(i_valid, LATENCY) && since_rst >= LATENCY) |-> o_valid)
        else $error("no o_valid %0d cycles after i_valid", LATENCY);

    a_latency_back: assert property (@(posedge Clk) disable iff (Rst_n)
        o_valid |-> $past(i_valid, LATENCY))
        else $error("o_valid without an i_valid %0d cycles before", LATENCY);

    a_in_spacing: assert property (@(posedge Clk) disable iff (Rst_n)
        i_valid |-> since_in >= 5'(`MD5_STAGE_LAT - 1))
        else $error("i_valid repeated within %0d cycles", `MD5_STAGE_LAT);

endmodule

bind md5_core md5_core_assert u_assert (
    .Clk     (Clk),
    .Rst_n   (Rst_n),
    .i_valid (i_valid),
    .o_valid (o_valid)
);

`default_nettype wire

// ==== dv/md5_core_tb.sv ====
`timescale 1ns/1ns
`include "md5_settings.svh"
`default_nettype none

module md5_core_tb
    import md5_pkg::*;
();

    localparam int CLK_PERIOD  = 20;
    localparam int RST_CYCLES  = 5;
    localparam int LATENCY     = 4 * `MD5_STAGE_LAT + 1;
    localparam int N_FULL      = 40;
    localparam int N_GAP       = 40;
    localparam int N_RST       = 3;
    localparam int N_BLOCKS    = 1 + N_FULL + N_GAP + N_RST + 2;
    localparam int WATCHDOG_NS = (N_BLOCKS + 2) * LATENCY * CLK_PERIOD
                                 + 2 * RST_CYCLES * CLK_PERIOD;

    logic   Clk;
    logic   Rst_n;
    logic   i_valid;
    block_t i_block;
    state_t i_chain;
    logic   o_valid;
    state_t o_digest;

    state_t     exp_q [$];          // Expected digests in issue order
    state_t     last_digest;
    int         strobe_cnt = 0;
    int         err_cnt = 0;
    word_t      k_tab [64];
    logic [4:0] s_tab [64];

    md5_core u_dut (
        .Clk      (Clk),
        .Rst_n    (Rst_n),
        .i_valid  (i_valid),
        .i_block  (i_block),
        .i_chain  (i_chain),
        .o_valid  (o_valid),
        .o_digest (o_digest)
    );

    initial
    begin
        Clk = 1'b0;
        forever #(CLK_PERIOD / 2) Clk = ~Clk;
    end

    task automatic stop_run();
        err_cnt++;
        $display("*** FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_error(input string why);
        $display("error at %0t ns: %s", $time, why);
        stop_run();
    endtask

    task automatic compare_state(input state_t got, input state_t exp, input string what);
        if (got !== exp)
        begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        if (got != exp)
        begin
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            stop_run();
        end
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        report_error($sformatf("run timed out with %0d digests still expected", exp_q.size()));
    end

    function automatic word_t rotl(input word_t x, input int s);
        return (x << s) | (x >> (32 - s));
    endfunction

    // Constants from the sine table, rotate amounts per round
    task automatic build_tables();
        real r;
        int  rot [4][4];
        rot = '{'{7, 12, 17, 22}, '{5, 9, 14, 20}, '{4, 11, 16, 23}, '{6, 10, 15, 21}};
        for (int i = 0; i < 64; i++)
        begin
            r = $sin(real'(i + 1));
            if (r < 0.0)
                r = -r;
            k_tab[i] = word_t'(longint'($floor(r * 4294967296.0)));
            s_tab[i] = 5'(rot[i / 16][i % 4]);
        end
    endtask

    // Reference compression of one block, feed-forward included
    function automatic state_t md5_model(input state_t chain, input block_t blk);
        word_t  a;
        word_t  b;
        word_t  c;
        word_t  d;
        word_t  f;
        word_t  t;
        int     g;
        state_t res;
        a = chain.a;
        b = chain.b;
        c = chain.c;
        d = chain.d;
        for (int i = 0; i < 64; i++)
        begin
            if (i < 16)
            begin
                f = (b & c) | (~b & d);
                g = i;
            end
            else if (i < 32)
            begin
                f = (d & b) | (~d & c);
                g = (5 * i + 1) % 16;
            end
            else if (i < 48)
            begin
                f = b ^ c ^ d;
                g = (3 * i + 5) % 16;
            end
            else
            begin
                f = c ^ (b | ~d);
                g = (7 * i) % 16;
            end
            t = d;
            d = c;
            c = b;
            b = b + rotl(a + f + k_tab[i] + blk[32 * g +: 32], s_tab[i]);
            a = t;
        end
        res.a = chain.a + a;
        res.b = chain.b + b;
        res.c = chain.c + c;
        res.d = chain.d + d;
        return res;
    endfunction

    function automatic block_t random_block();
        block_t blk;
        for (int w = 0; w < 16; w++)
            blk[32 * w +: 32] = $urandom();
        return blk;
    endfunction

    function automatic state_t random_state();
        state_t s;
        s = {$urandom(), $urandom(), $urandom(), $urandom()};
        return s;
    endfunction

    // One strobe, then idle so that strobes are gap cycles apart
    task automatic send_block(input block_t blk, input state_t chain, input state_t exp,
                              input int gap);
        exp_q.push_back(exp);
        @(posedge Clk);
        i_valid <= 1'b1;
        i_block <= blk;
        i_chain <= chain;
        @(posedge Clk);
        i_valid <= 1'b0;
        repeat (gap - 2) @(posedge Clk);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0)
        begin
            @(posedge Clk);
            n++;
            if (n > 2 * LATENCY)
                report_error($sformatf("no digest within %0d cycles, %0d still expected",
                                       2 * LATENCY, exp_q.size()));
        end
        repeat (2) @(posedge Clk);
    endtask

    // Scoreboard, outputs read mid-cycle
    always @(negedge Clk)
    begin
        if (Rst_n && o_valid)
            report_error("o_valid high while reset is active");
        else if (o_valid)
        begin
            strobe_cnt++;
            last_digest = o_digest;
            if (exp_q.size() == 0)
                report_error("digest appeared with no block outstanding");
            else
                compare_state(o_digest, exp_q.pop_front(), "digest");
        end
    end

    initial
    begin
        state_t iv;
        state_t exp;
        state_t chain;
        state_t d1;
        block_t blk;
        block_t blk2;
        int     base_cnt;

        void'($urandom(32'hac2c));
        build_tables();
        Rst_n   = 1'b1;
        i_valid = 1'b0;
        i_block = '0;
        i_chain = '0;
        iv = {`MD5_IV_D, `MD5_IV_C, `MD5_IV_B, `MD5_IV_A};
        repeat (RST_CYCLES) @(posedge Clk);
        Rst_n <= 1'b0;
        repeat (2) @(posedge Clk);

        // Padded empty message
        blk = '0;
        blk[31:0] = 32'h80;
        exp = {32'h7e42f8ec, 32'h980980e9, 32'h04b2008f, 32'hd98c1dd4};
        compare_state(md5_model(iv, blk), exp, "model on empty message");
        send_block(blk, iv, exp, `MD5_STAGE_LAT);
        wait_drain();

        for (int n = 0; n < N_FULL; n++)
        begin
            blk   = random_block();
            chain = random_state();
            send_block(blk, chain, md5_model(chain, blk), `MD5_STAGE_LAT);
        end
        wait_drain();

        base_cnt = strobe_cnt;
        for (int n = 0; n < N_GAP; n++)
        begin
            blk   = random_block();
            chain = random_state();
            send_block(blk, chain, md5_model(chain, blk),
                       `MD5_STAGE_LAT + int'($urandom_range(43)));
        end
        wait_drain();
        compare_count(strobe_cnt - base_cnt, N_GAP, "o_valid strobes in gap test");

        // Reset while every block is still inside the pipeline
        base_cnt = strobe_cnt;
        for (int n = 0; n < N_RST; n++)
        begin
            blk   = random_block();
            chain = random_state();
            send_block(blk, chain, md5_model(chain, blk), `MD5_STAGE_LAT);
        end
        @(posedge Clk);
        Rst_n <= 1'b1;
        exp_q.delete();
        repeat (RST_CYCLES) @(posedge Clk);
        Rst_n <= 1'b0;
        repeat (2 * LATENCY) @(posedge Clk);
        compare_count(strobe_cnt - base_cnt, 0, "o_valid strobes after mid-flight reset");

        blk  = random_block();
        blk2 = random_block();
        d1   = md5_model(iv, blk);
        send_block(blk, iv, d1, `MD5_STAGE_LAT);
        wait_drain();
        send_block(blk2, last_digest, md5_model(d1, blk2), `MD5_STAGE_LAT);    // Fed back
        wait_drain();

        if (err_cnt == 0)
        begin
            $display("*** PASSED ***");
            $finish;
        end
        else
        begin
            $display("*** FAILED ***");
            $fatal(1, "errors were reported");
        end
    end

endmodule

`default_nettype wire

// ==== md5_core.f ====
+incdir+design
design/md5_pkg.sv
design/md5_const_rom.sv
design/md5_round_stage.sv
design/md5_digest_stage.sv
design/md5_core.sv
dv/md5_core_assert.sv
dv/md5_core_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := md5_core_tb
FILELIST   := md5_core.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0 -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "\*\*\* PASSED \*\*\*" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
